//--- src/alu_pkg.sv
package alu_pkg;

	// datapath and flag widths
	localparam int DATA_W = 16;
	localparam int FLAG_W = 3;

	// bit positions inside the flag register
	localparam int FLAG_Z = 0;	// zero
	localparam int FLAG_V = 1;	// signed overflow
	localparam int FLAG_N = 2;	// negative

	//////////////////////////////////////////////////
	// opcode encoding
	//////////////////////////////////////////////////
	// bit 3 set means memory or byte load
	// codes 12..15 are not listed and fall through to llb
	typedef enum logic [3:0] {
		ADD    = 4'd0,	// saturating add
		SUB    = 4'd1,	// saturating subtract
		XOR    = 4'd2,
		RED    = 4'd3,	// byte reduction
		SLL    = 4'd4,	// shift left logical
		SRA    = 4'd5,	// shift right arithmetic
		ROR    = 4'd6,	// rotate right
		PADDSB = 4'd7,	// nibble add, saturating
		LW     = 4'd8,	// load word address
		SW     = 4'd9,	// store word address
		LHB    = 4'd10,	// load high byte
		LLB    = 4'd11	// load low byte
	} alu_op_e;

endpackage

//--- src/alu_adder.sv
`timescale 1ns/10ps

module alu_adder import alu_pkg::*; (
	input  logic              mode_i,	// 1 = subtract
	input  logic [DATA_W-1:0] a_i,
	input  logic [DATA_W-1:0] b_i,
	input  logic              sat_i,	// clamp on signed overflow
	output logic [DATA_W-1:0] sum_o,
	output logic              n_o,
	output logic              v_o,
	output logic              z_o
);

	logic [DATA_W-1:0] b_eff;	// b or its complement
	logic [DATA_W-1:0] raw_sum;	// unclamped two's complement result
	logic              ovf;

	// subtract is a + ~b + 1
	assign b_eff = mode_i ? ~b_i : b_i;
	assign raw_sum = a_i + b_eff + {{(DATA_W-1){1'b0}}, mode_i};

	// overflow when both addends share a sign and the sum does not
	assign ovf = (a_i[DATA_W-1] == b_eff[DATA_W-1]) &&
		(raw_sum[DATA_W-1] != a_i[DATA_W-1]);

	//////////////////////////////////////////////////
	// saturation
	//////////////////////////////////////////////////
	always_comb begin
		sum_o = raw_sum;
		if (sat_i && ovf) begin
			// sign of a tells which rail was crossed
			if (a_i[DATA_W-1])
				sum_o = {1'b1, {(DATA_W-1){1'b0}}};	// most negative
			else
				sum_o = {1'b0, {(DATA_W-1){1'b1}}};	// most positive
		end
	end

	// flags
	assign v_o = ovf;	// reported before clamping
	assign n_o = sum_o[DATA_W-1];	// sign of what leaves
	assign z_o = (sum_o == '0);

endmodule

//--- src/alu_shifter.sv
`timescale 1ns/10ps

module alu_shifter import alu_pkg::*; (
	input  logic [1:0]        mode_i,	// 0 sll, 1 sra, 2/3 ror
	input  logic [DATA_W-1:0] data_i,
	input  logic [3:0]        amount_i,	// 0..15 places
	output logic [DATA_W-1:0] data_o
);

	// stage[k] is the value after the first k log stages
	logic [DATA_W-1:0] stage [0:4];

	assign stage[0] = data_i;

	//////////////////////////////////////////////////
	// log stages of 1, 2, 4 and 8 places
	//////////////////////////////////////////////////
	genvar k;
	for (k = 0; k < 4; k++) begin : g_stage
		logic [DATA_W-1:0] shifted;	// this stage's fixed shift

		always_comb begin
			case (mode_i)
				2'd0: begin
					shifted = stage[k] << (2**k);	// zero fill from the right
				end
				2'd1: begin
					// sign fill from the left
					shifted = $signed(stage[k]) >>> (2**k);
				end
				default: begin
					// low bits wrap round to the top
					shifted = {stage[k][(2**k)-1:0], stage[k][DATA_W-1:(2**k)]};
				end
			endcase
		end

		// stage only acts when its amount bit is set
		assign stage[k+1] = amount_i[k] ? shifted : stage[k];
	end

	assign data_o = stage[4];

endmodule

//--- src/alu_simd.sv
`timescale 1ns/10ps

module alu_simd import alu_pkg::*; (
	input  logic [DATA_W-1:0] a_i,
	input  logic [DATA_W-1:0] b_i,
	output logic [DATA_W-1:0] red_o,	// sum of four signed bytes
	output logic [DATA_W-1:0] paddsb_o	// four saturated nibble sums
);

	//////////////////////////////////////////////////
	// byte reduction
	//////////////////////////////////////////////////
	logic [9:0] a_hi, a_lo, b_hi, b_lo;	// bytes sign extended to 10 bits
	logic [9:0] red_sum;

	assign a_hi = {{2{a_i[15]}}, a_i[15:8]};
	assign a_lo = {{2{a_i[7]}}, a_i[7:0]};
	assign b_hi = {{2{b_i[15]}}, b_i[15:8]};
	assign b_lo = {{2{b_i[7]}}, b_i[7:0]};

	// four 8-bit values never overflow 10 bits
	assign red_sum = a_hi + a_lo + b_hi + b_lo;
	assign red_o = {{(DATA_W-10){red_sum[9]}}, red_sum};

	//////////////////////////////////////////////////
	// nibble-wise saturating add
	//////////////////////////////////////////////////
	genvar n;
	for (n = 0; n < 4; n++) begin : g_lane
		logic [4:0] lane_sum;	// one guard bit above the nibble

		assign lane_sum = {a_i[4*n+3], a_i[4*n +: 4]} + {b_i[4*n+3], b_i[4*n +: 4]};

		always_comb begin
			// guard and sign disagree on overflow
			if (lane_sum[4] != lane_sum[3]) begin
				if (lane_sum[4])
					paddsb_o[4*n +: 4] = 4'h8;	// clamp at -8
				else
					paddsb_o[4*n +: 4] = 4'h7;	// clamp at +7
			end else begin
				paddsb_o[4*n +: 4] = lane_sum[3:0];
			end
		end
	end

endmodule

//--- src/alu_execute_stage.sv
`timescale 1ns/10ps

module alu_execute_stage import alu_pkg::*; (
	input  logic              clk,
	input  logic              reset_i,
	// upstream handshake
	input  logic              in_valid_i,
	output logic              in_ready_o,
	input  alu_op_e           opcode_i,
	input  logic [DATA_W-1:0] a_i,	// first operand or base address
	input  logic [DATA_W-1:0] b_i,	// second operand, shift amount or offset
	// towards the flag stage
	output logic              ex_valid_o,
	input  logic              ex_ready_i,
	output logic [DATA_W-1:0] ex_result_o,
	output logic [FLAG_W-1:0] ex_flag_cand_o,	// new flag values
	output logic [FLAG_W-1:0] ex_flag_we_o	// which flags to write
);

	logic              is_mem;	// lw or sw
	logic              is_arith;	// add or sub
	logic [DATA_W-1:0] add_a, add_b;
	logic [DATA_W-1:0] add_sum, shift_out, red_out, paddsb_out;
	logic              add_n, add_v;
	logic [DATA_W-1:0] result;
	logic [FLAG_W-1:0] flag_cand, flag_we;

	assign is_mem = (opcode_i == LW) || (opcode_i == SW);
	assign is_arith = (opcode_i == ADD) || (opcode_i == SUB);

	// addresses are word aligned and the offset is stored doubled
	assign add_a = is_mem ? {a_i[DATA_W-1:1], 1'b0} : a_i;
	assign add_b = is_mem ? (b_i >> 1) : b_i;

	alu_adder i_adder (
		.mode_i (opcode_i == SUB),
		.a_i    (add_a),
		.b_i    (add_b),
		.sat_i  (is_arith),	// address math wraps
		.sum_o  (add_sum),
		.n_o    (add_n),
		.v_o    (add_v),
		.z_o    ()
	);

	alu_shifter i_shifter (.mode_i(opcode_i[1:0]), .data_i(a_i), .amount_i(b_i[3:0]),
		.data_o(shift_out));

	alu_simd i_simd (.a_i(a_i), .b_i(b_i), .red_o(red_out), .paddsb_o(paddsb_out));

	//////////////////////////////////////////////////
	// result select
	//////////////////////////////////////////////////
	always_comb begin
		case (opcode_i)
			ADD, SUB, LW, SW: result = add_sum;
			PADDSB:           result = paddsb_out;
			SLL, SRA, ROR:    result = shift_out;
			RED:              result = red_out;
			XOR:              result = a_i ^ b_i;
			LHB:              result = {b_i[7:0], a_i[7:0]};
			default:          result = {a_i[15:8], b_i[7:0]};	// llb and spare codes
		endcase
	end

	// flag candidates
	assign flag_cand[FLAG_Z] = (result == '0);
	assign flag_cand[FLAG_V] = add_v;
	assign flag_cand[FLAG_N] = add_n;

	// z for low opcodes bar the lane ops
	assign flag_we[FLAG_Z] = ~(opcode_i[3] | (opcode_i == RED) | (opcode_i == PADDSB));
	assign flag_we[FLAG_V] = is_arith;	// v and n only for add and sub
	assign flag_we[FLAG_N] = is_arith;

	//////////////////////////////////////////////////
	// stage register
	//////////////////////////////////////////////////
	assign in_ready_o = ~ex_valid_o | ex_ready_i;	// empty or draining

	always_ff @(posedge clk) begin
		if (reset_i)
			ex_valid_o <= 1'b0;
		else if (in_ready_o)
			ex_valid_o <= in_valid_i;
	end

	always_ff @(posedge clk) begin
		if (in_valid_i && in_ready_o) begin	// payload only on accept
			ex_result_o    <= result;
			ex_flag_cand_o <= flag_cand;
			ex_flag_we_o   <= flag_we;
		end
	end

endmodule

//--- src/alu_flag_stage.sv
`timescale 1ns/10ps

module alu_flag_stage import alu_pkg::*; (
	input  logic              clk,
	input  logic              reset_i,
	// from the execute stage
	input  logic              ex_valid_i,
	output logic              ex_ready_o,
	input  logic [DATA_W-1:0] ex_result_i,
	input  logic [FLAG_W-1:0] ex_flag_cand_i,
	input  logic [FLAG_W-1:0] ex_flag_we_i,
	// downstream handshake
	output logic              out_valid_o,
	input  logic              out_ready_i,
	output logic [DATA_W-1:0] result_o,
	output logic [FLAG_W-1:0] flag_o	// flag register contents
);

	logic              ex_take;	// item moves in this cycle
	logic [FLAG_W-1:0] flag_q;
	logic [FLAG_W-1:0] flag_d;

	// ready when empty or when the consumer takes the current item
	assign ex_ready_o = ~out_valid_o | out_ready_i;
	assign ex_take = ex_valid_i & ex_ready_o;

	//////////////////////////////////////////////////
	// flag register
	//////////////////////////////////////////////////
	// each bit keeps its old value unless its enable is set
	always_comb begin
		for (int i = 0; i < FLAG_W; i++) begin
			flag_d[i] = ex_flag_we_i[i] ? ex_flag_cand_i[i] : flag_q[i];
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i)
			flag_q <= '0;
		else if (ex_take)
			flag_q <= flag_d;	// same edge as the result
	end

	assign flag_o = flag_q;

	//////////////////////////////////////////////////
	// output register
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset_i) begin
			out_valid_o <= 1'b0;
			result_o    <= '0;
		end else begin
			if (ex_ready_o)
				out_valid_o <= ex_valid_i;	// drops when nothing follows
			if (ex_take)
				result_o <= ex_result_i;	// held while stalled
		end
	end

endmodule

//--- src/alu_pipe_top.sv
`timescale 1ns/10ps

module alu_pipe_top import alu_pkg::*; (
	input  logic              clk,
	input  logic              reset_i,	// synchronous, active high
	// operation input
	input  logic              in_valid_i,
	output logic              in_ready_o,
	input  alu_op_e           opcode_i,
	input  logic [DATA_W-1:0] a_i,
	input  logic [DATA_W-1:0] b_i,
	// result output
	output logic              out_valid_o,
	input  logic              out_ready_i,
	output logic [DATA_W-1:0] result_o,
	output logic [FLAG_W-1:0] flag_o	// n, v, z after this result
);

	//////////////////////////////////////////////////
	// stage 1 to stage 2
	//////////////////////////////////////////////////
	logic              ex_valid;
	logic              ex_ready;
	logic [DATA_W-1:0] ex_result;
	logic [FLAG_W-1:0] ex_flag_cand;
	logic [FLAG_W-1:0] ex_flag_we;

	// stage 1, compute and register
	alu_execute_stage i_execute (
		.clk            (clk),
		.reset_i        (reset_i),
		.in_valid_i     (in_valid_i),
		.in_ready_o     (in_ready_o),
		.opcode_i       (opcode_i),
		.a_i            (a_i),
		.b_i            (b_i),
		.ex_valid_o     (ex_valid),
		.ex_ready_i     (ex_ready),
		.ex_result_o    (ex_result),
		.ex_flag_cand_o (ex_flag_cand),
		.ex_flag_we_o   (ex_flag_we)
	);

	// stage 2, flags and output
	alu_flag_stage i_flag (
		.clk            (clk),
		.reset_i        (reset_i),
		.ex_valid_i     (ex_valid),
		.ex_ready_o     (ex_ready),
		.ex_result_i    (ex_result),
		.ex_flag_cand_i (ex_flag_cand),
		.ex_flag_we_i   (ex_flag_we),
		.out_valid_o    (out_valid_o),
		.out_ready_i    (out_ready_i),
		.result_o       (result_o),
		.flag_o         (flag_o)
	);

endmodule

//--- test/alu_pipe_tb.sv
`timescale 1ns/10ps

module alu_pipe_tb import alu_pkg::*; ();

	localparam int CLK_PERIOD = 100;
	localparam int STIM_DELAY = 10;	// drive after the rising edge
	localparam int N_ARITH    = 16;	// random add/sub
	localparam int N_LOGIC    = 6;	// random per logic/shift opcode
	localparam int N_LANE     = 8;	// random per lane opcode
	localparam int N_MEM      = 6;	// random per memory/byte opcode
	localparam int N_STREAM   = 200;
	// directed and random ops over all tests
	localparam int N_OPS = 1 + (9 + N_ARITH) + (5 + 4*N_LOGIC) + (7 + 2*N_LANE)
		+ (7 + 4*N_MEM) + N_STREAM;

	logic              clk;
	logic              reset_i;
	logic              in_valid_i;
	logic              in_ready_o;
	alu_op_e           opcode_i;
	logic [DATA_W-1:0] a_i, b_i;
	logic              out_valid_o;
	logic              out_ready_i;
	logic [DATA_W-1:0] result_o;
	logic [FLAG_W-1:0] flag_o;

	logic [15:0]       lfsr_state;
	logic [FLAG_W-1:0] model_flags;	// flag state in issue order
	logic [15:0]       exp_result_q [$];	// pending results
	logic [FLAG_W-1:0] exp_flag_q [$];
	alu_op_e           exp_op_q [$];
	int                error_count, check_count, issued, received;

	alu_pipe_top i_dut (
		.clk         (clk),
		.reset_i     (reset_i),
		.in_valid_i  (in_valid_i),
		.in_ready_o  (in_ready_o),
		.opcode_i    (opcode_i),
		.a_i         (a_i),
		.b_i         (b_i),
		.out_valid_o (out_valid_o),
		.out_ready_i (out_ready_i),
		.result_o    (result_o),
		.flag_o      (flag_o)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	//////////////////////////////////////////////////
	// random source and reference model
	//////////////////////////////////////////////////
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hB400;	// x^16 + x^14 + x^13 + x^11 + 1
		return s >> 1;
	endfunction

	// one lfsr step per bit handed out
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[14:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// returns {overflow, result}
	function automatic logic [16:0] model_exec(input alu_op_e op, input logic [15:0] a,
		input logic [15:0] b);
		int          sa, sb, s;
		logic [15:0] res;
		logic [31:0] twice;	// a twice over for the rotate
		logic        ovf;
		sa = $signed(a);
		sb = $signed(b);
		ovf = 1'b0;
		res = '0;
		case (op)
			ADD, SUB: begin
				s = (op == SUB) ? sa - sb : sa + sb;	// exact without wrap
				ovf = (s > 32767) || (s < -32768);
				if (s > 32767)
					res = 16'h7FFF;
				else if (s < -32768)
					res = 16'h8000;
				else
					res = s[15:0];
			end
			XOR: res = a ^ b;
			RED: begin
				s = int'($signed(a[15:8])) + int'($signed(a[7:0]))
					+ int'($signed(b[15:8])) + int'($signed(b[7:0]));
				res = s[15:0];	// sign carries up from 32 bits
			end
			SLL: res = a << b[3:0];
			SRA: res = $signed(a) >>> b[3:0];
			ROR: begin
				twice = {a, a} >> b[3:0];
				res = twice[15:0];
			end
			PADDSB: begin
				for (int i = 0; i < 4; i++) begin
					s = int'($signed(a[4*i +: 4])) + int'($signed(b[4*i +: 4]));
					if (s > 7)
						s = 7;
					else if (s < -8)
						s = -8;
					res[4*i +: 4] = s[3:0];
				end
			end
			LW, SW: res = (a & 16'hFFFE) + (b >> 1);	// word base plus halved offset
			LHB: res = {b[7:0], a[7:0]};
			default: res = {a[15:8], b[7:0]};	// llb and the spare codes
		endcase
		return {ovf, res};
	endfunction

	// queue the expected response and advance the model flags
	task automatic predict_op(input alu_op_e op, input logic [15:0] a, input logic [15:0] b);
		logic [16:0] out;
		logic [15:0] res;
		out = model_exec(op, a, b);
		res = out[15:0];
		if (op == ADD || op == SUB) begin
			model_flags[FLAG_Z] = (res == 16'h0000);
			model_flags[FLAG_V] = out[16];
			model_flags[FLAG_N] = res[15];
		end else if (op == XOR || op == SLL || op == SRA || op == ROR) begin
			model_flags[FLAG_Z] = (res == 16'h0000);	// v and n hold
		end
		exp_result_q.push_back(res);
		exp_flag_q.push_back(model_flags);
		exp_op_q.push_back(op);
	endtask

	//////////////////////////////////////////////////
	// checking, driving and output monitor
	//////////////////////////////////////////////////
	task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
		input string msg);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("mismatch at %0t: %s (got %h, expected %h)", $time, msg, got, exp);
		end
	endtask

	// called and returns at edge + STIM_DELAY
	task automatic send_op(input alu_op_e op, input logic [15:0] a, input logic [15:0] b);
		logic accepted;
		predict_op(op, a, b);
		in_valid_i = 1'b1;
		opcode_i = op;
		a_i = a;
		b_i = b;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge clk);
			accepted = in_ready_o;	// transfer on the coming edge
			@(posedge clk);
			#STIM_DELAY;
		end
		in_valid_i = 1'b0;
		issued++;
	endtask

	task automatic wait_drain();
		while (exp_result_q.size() != 0)
			@(negedge clk);
		@(posedge clk);
		#STIM_DELAY;
	endtask

	task automatic end_test(input string name, input int errors_before);
		$display("%-20s done at %0t, %0d errors", name, $time, error_count - errors_before);
	endtask

	// samples mid-cycle where handshake and data are settled
	initial begin : monitor
		logic              stalled;	// valid without ready last sample
		logic [15:0]       held_result, r;
		logic [FLAG_W-1:0] held_flags, f;
		alu_op_e           op;
		stalled = 1'b0;
		forever begin
			@(negedge clk);
			if (!reset_i) begin
				if (stalled) begin
					check_equal(out_valid_o, 1'b1, "valid dropped while stalled");
					check_equal(result_o, held_result, "result moved while stalled");
					check_equal(flag_o, held_flags, "flags moved while stalled");
				end
				stalled = (out_valid_o === 1'b1) && !out_ready_i;
				held_result = result_o;
				held_flags = flag_o;
				if (out_valid_o === 1'b1 && out_ready_i) begin
					if (exp_result_q.size() == 0) begin
						error_count++;
						$display("an output appeared at %0t with no operation pending", $time);
					end else begin
						r = exp_result_q.pop_front();
						f = exp_flag_q.pop_front();
						op = exp_op_q.pop_front();
						received++;
						check_equal(result_o, r, $sformatf("result #%0d %s", received, op.name()));
						check_equal(flag_o, f, $sformatf("flags #%0d %s", received, op.name()));
					end
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////
	task automatic reset_and_latency();
		int errors_before;
		errors_before = error_count;
		check_equal(out_valid_o, 1'b0, "out_valid_o after reset");
		check_equal(in_ready_o, 1'b1, "in_ready_o after reset");
		check_equal(flag_o, 3'b000, "flag_o after reset");
		check_equal(result_o, 16'h0000, "result_o after reset");
		send_op(ADD, 16'h0123, 16'h0456);
		@(negedge clk);
		check_equal(out_valid_o, 1'b0, "out_valid_o one cycle after accept");
		@(negedge clk);
		check_equal(out_valid_o, 1'b1, "out_valid_o two cycles after accept");
		wait_drain();
		end_test("reset_and_latency", errors_before);
	endtask

	task automatic add_sub_ops();
		int          errors_before;
		logic [15:0] a, b;
		alu_op_e     op;
		errors_before = error_count;
		send_op(ADD, 16'h7FFF, 16'h0001);	// clamps high
		send_op(ADD, 16'h8000, 16'hFFFF);	// clamps low
		send_op(ADD, 16'h8000, 16'h8000);
		send_op(ADD, 16'h0001, 16'hFFFF);	// zero
		send_op(ADD, 16'h1234, 16'h4321);
		send_op(SUB, 16'h8000, 16'h0001);
		send_op(SUB, 16'h7FFF, 16'hFFFF);
		send_op(SUB, 16'h0000, 16'h8000);	// negating the minimum
		send_op(SUB, 16'h1234, 16'h1234);
		for (int i = 0; i < N_ARITH; i++) begin
			op = rand_bits(1) ? SUB : ADD;
			a = rand_bits(16);
			b = rand_bits(16);
			send_op(op, a, b);
		end
		wait_drain();
		end_test("add_sub_ops", errors_before);
	endtask

	task automatic logic_and_shift_ops();
		int          errors_before;
		logic [15:0] a, b;
		alu_op_e     op_list [0:3] = '{XOR, SLL, SRA, ROR};
		errors_before = error_count;
		send_op(ADD, 16'h8000, 16'hFFFF);	// n and v set first
		send_op(XOR, 16'h5A5A, 16'h5A5A);
		send_op(SLL, 16'h8000, 16'h0001);	// top bit falls off
		send_op(SRA, 16'h8000, 16'h000F);
		send_op(ROR, 16'h0001, 16'h0011);	// only low 4 bits count
		for (int i = 0; i < N_LOGIC; i++) begin
			for (int j = 0; j < 4; j++) begin
				a = rand_bits(16);
				b = rand_bits(16);
				send_op(op_list[j], a, b);
			end
		end
		wait_drain();
		end_test("logic_and_shift_ops", errors_before);
	endtask

	task automatic lane_ops();
		int          errors_before;
		logic [15:0] a, b;
		errors_before = error_count;
		send_op(ADD, 16'h8000, 16'hFFFF);
		send_op(RED, 16'h7F7F, 16'h7F7F);	// largest sum
		send_op(RED, 16'h8080, 16'h8080);	// smallest sum
		send_op(RED, 16'h00FF, 16'h0100);	// sums to zero with z untouched
		send_op(PADDSB, 16'h7777, 16'h1111);
		send_op(PADDSB, 16'h8888, 16'hFFFF);
		send_op(PADDSB, 16'h1234, 16'h4321);
		for (int i = 0; i < N_LANE; i++) begin
			a = rand_bits(16);
			b = rand_bits(16);
			send_op(RED, a, b);
			a = rand_bits(16);
			b = rand_bits(16);
			send_op(PADDSB, a, b);
		end
		wait_drain();
		end_test("lane_ops", errors_before);
	endtask

	task automatic memory_and_byte_ops();
		int          errors_before;
		logic [15:0] a, b;
		alu_op_e     op_list [0:3] = '{LW, SW, LHB, LLB};
		errors_before = error_count;
		send_op(ADD, 16'h8000, 16'hFFFF);
		send_op(LW, 16'h1001, 16'h0006);	// odd base
		send_op(SW, 16'hFFFF, 16'h0004);	// wraps to zero
		send_op(LW, 16'h0000, 16'h8000);	// offset shift is logical
		send_op(LHB, 16'h1234, 16'hABCD);
		send_op(LLB, 16'h1234, 16'hABCD);
		send_op(alu_op_e'(4'd12), 16'h1234, 16'h00EF);	// spare code
		for (int i = 0; i < N_MEM; i++) begin
			for (int j = 0; j < 4; j++) begin
				a = rand_bits(16);
				b = rand_bits(16);
				send_op(op_list[j], a, b);
			end
		end
		wait_drain();
		end_test("memory_and_byte_ops", errors_before);
	endtask

	// random ops against random back-pressure
	task automatic random_stream();
		int          errors_before;
		logic [3:0]  code;
		alu_op_e     ops [N_STREAM];
		logic [15:0] a_list [N_STREAM];
		logic [15:0] b_list [N_STREAM];
		logic        stream_done;
		errors_before = error_count;
		stream_done = 1'b0;
		for (int i = 0; i < N_STREAM; i++) begin	// draw operands up front
			code = rand_bits(4);
			ops[i] = alu_op_e'(code);
			a_list[i] = rand_bits(16);
			b_list[i] = rand_bits(16);
		end
		fork
			begin
				for (int i = 0; i < N_STREAM; i++)
					send_op(ops[i], a_list[i], b_list[i]);
				wait_drain();
				stream_done = 1'b1;
			end
			begin
				while (!stream_done) begin
					@(posedge clk);
					#STIM_DELAY;
					if (!stream_done)
						out_ready_i = rand_bits(1);
				end
			end
		join
		out_ready_i = 1'b1;
		end_test("random_stream", errors_before);
	endtask

	//////////////////////////////////////////////////
	// run
	//////////////////////////////////////////////////
	initial begin
		reset_i = 1'b1;
		in_valid_i = 1'b0;
		opcode_i = ADD;
		a_i = '0;
		b_i = '0;
		out_ready_i = 1'b1;
		lfsr_state = 16'd20758;
		model_flags = '0;
		error_count = 0;
		check_count = 0;
		issued = 0;
		received = 0;
		repeat (5) @(posedge clk);
		#STIM_DELAY;
		reset_i = 1'b0;

		reset_and_latency();
		add_sub_ops();
		logic_and_shift_ops();
		lane_ops();
		memory_and_byte_ops();
		random_stream();

		$display("%0d ops issued, %0d results, %0d checks, %0d errors",
			issued, received, check_count, error_count);
		if (error_count == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	// 20 cycles per operation is far above the worst stall pattern
	initial begin : watchdog
		#((N_OPS * 20 + 50) * CLK_PERIOD);
		$display("timeout: the run did not end within %0d cycles", N_OPS * 20 + 50);
		$display("Test failed");
		$finish;
	end

endmodule

//--- compile.f
src/alu_pkg.sv
src/alu_adder.sv
src/alu_shifter.sv
src/alu_simd.sv
src/alu_execute_stage.sv
src/alu_flag_stage.sv
src/alu_pipe_top.sv
test/alu_pipe_tb.sv
